// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       := minv_tb
FILELIST  := files.f
BUILD     := obj_dir
LOG       := sim.log
PASS_TEXT := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== files.f ====
+incdir+tests
hw/minv_pkg.sv
hw/minv_divsqrt.sv
hw/minv_regs.sv
hw/minv_factor.sv
hw/minv_gram.sv
hw/minv_top.sv
tests/minv_tb.sv

// ==== hw/minv_divsqrt.sv ====
// ####################################################################
// fixed 34-cycle latency; requests arriving while busy are dropped
// ####################################################################
module minv_divsqrt (
	input  logic                 i,
	input  logic                 arst_n,
	input  minv_pkg::arith_req_t req,
	output minv_pkg::arith_rsp_t rsp
);
	minv_pkg::arith_op_e op_q;
	logic neg_q;
	logic fault_q;
	logic [31:0] den_q;
	logic [63:0] sh;
	logic [35:0] rem;
	logic [35:0] rem_n;
	logic [31:0] acc;
	logic [31:0] acc_n;
	logic [4:0] cnt;
	logic run;
	logic fin;
	logic rsp_valid;
	logic take;
	logic [31:0] num_mag;
	logic [31:0] den_mag;

	assign take = req.valid && !run && !fin;
	assign num_mag = req.arg.div.num[31] ? -req.arg.div.num : req.arg.div.num;
	assign den_mag = req.arg.div.den[31] ? -req.arg.div.den : req.arg.div.den;

	// both ops consume two bits of sh per cycle
	always_comb begin
		logic [35:0] t;
		logic [35:0] trial;
		t = '0;
		trial = '0;
		rem_n = rem;
		acc_n = acc;
		if (op_q == minv_pkg::OP_DIV) begin
			for (int s = 0; s < 2; s++) begin
				t = {rem_n[34:0], sh[63-s]};
				if (t >= {4'b0, den_q}) begin
					rem_n = t - {4'b0, den_q};
					acc_n = {acc_n[30:0], 1'b1};
				end else begin
					rem_n = t;
					acc_n = {acc_n[30:0], 1'b0};
				end
			end
		end else begin
			t = {rem_n[33:0], sh[63:62]};
			trial = {2'b0, acc_n, 2'b01};
			if (t >= trial) begin
				rem_n = t - trial;
				acc_n = {acc_n[30:0], 1'b1};
			end else begin
				rem_n = t;
				acc_n = {acc_n[30:0], 1'b0};
			end
		end
	end

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
			fin <= 1'b0;
			cnt <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= fin;
			fin <= 1'b0;
			if (take) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				cnt <= cnt + 1'b1;
				if (cnt == 5'd31) begin
					run <= 1'b0;
					fin <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (take) begin
			op_q <= req.op;
			rem <= '0;
			acc <= '0;
			if (req.op == minv_pkg::OP_DIV) begin
				sh <= 64'(num_mag) << minv_pkg::FRAC;
				den_q <= den_mag;
				neg_q <= req.arg.div.num[31] ^ req.arg.div.den[31];
				fault_q <= req.arg.div.den == '0;
			end else begin
				sh <= req.arg.radicand;
				den_q <= '0;
				neg_q <= 1'b0;
				// top bit set means a negative value was shifted in
				fault_q <= req.arg.radicand == '0 || req.arg.radicand[63];
			end
		end else if (run) begin
			sh <= sh << 2;
			rem <= rem_n;
			acc <= acc_n;
		end
	end

	// quotient magnitude holds after the last step, sign applied here
	assign rsp.valid = rsp_valid;
	assign rsp.result = neg_q ? -acc : acc;
	assign rsp.fault = fault_q;

endmodule

// ==== hw/minv_factor.sv ====
// ####################################################################
// reads only the lower triangle of A; one request to the shared unit
// at a time, any fault aborts the run
// ####################################################################
module minv_factor #(
	parameter int N = 3
) (
	input  logic                      i,
	input  logic                      arst_n,
	input  logic                      start,
	input  minv_pkg::word_t [N*N-1:0] a_mat,
	output minv_pkg::arith_req_t      arith_req,
	input  minv_pkg::arith_rsp_t      arith_rsp,
	output minv_pkg::word_t [N*N-1:0] m_mat,
	output logic                      fact_done,
	output logic                      fact_fail
);
	localparam int IW = $clog2(N + 1);
	localparam logic [IW-1:0] LAST = IW'(N - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_INIT,
		S_MAC,
		S_WAIT
	} state_e;

	state_e state;
	logic inv_phase;
	logic [IW-1:0] r;
	logic [IW-1:0] c;
	logic [IW-1:0] k;
	logic [IW-1:0] k_end;
	logic signed [63:0] acc;
	logic signed [63:0] prod;
	minv_pkg::word_t l_mat [N][N];
	minv_pkg::word_t m_q [N][N];
	minv_pkg::word_t mul_a;
	minv_pkg::word_t mul_b;
	minv_pkg::word_t sum;

	// cholesky: l_rk*l_ck, inverse: l_rk*m_kc
	assign mul_a = l_mat[r][k];
	assign mul_b = inv_phase ? m_q[k][c] : l_mat[c][k];
	assign prod = mul_a * mul_b;
	assign sum = acc[31:0];
	assign k_end = inv_phase ? r : c;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			inv_phase <= 1'b0;
			r <= '0;
			c <= '0;
			k <= '0;
			arith_req <= '0;
			fact_done <= 1'b0;
			fact_fail <= 1'b0;
		end else begin
			arith_req.valid <= 1'b0;
			fact_done <= 1'b0;
			fact_fail <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						inv_phase <= 1'b0;
						r <= '0;
						c <= '0;
						state <= S_INIT;
					end
				end
				S_INIT: begin
					k <= inv_phase ? c : '0;
					state <= S_MAC;
				end
				S_MAC: begin
					if (k == k_end) begin
						arith_req.valid <= 1'b1;
						state <= S_WAIT;
						if (!inv_phase && r == c) begin
							arith_req.op <= minv_pkg::OP_SQRT;
							arith_req.arg.radicand <= 64'(sum) << minv_pkg::FRAC;
						end else if (!inv_phase) begin
							arith_req.op <= minv_pkg::OP_DIV;
							arith_req.arg.div.num <= sum;
							arith_req.arg.div.den <= l_mat[c][c];
						end else begin
							arith_req.op <= minv_pkg::OP_DIV;
							arith_req.arg.div.num <= (r == c) ? minv_pkg::ONE : -sum;
							arith_req.arg.div.den <= l_mat[r][r];
						end
					end else begin
						k <= k + 1'b1;
					end
				end
				S_WAIT: begin
					if (arith_rsp.valid) begin
						state <= S_INIT;
						if (arith_rsp.fault) begin
							fact_fail <= 1'b1;
							state <= S_IDLE;
						end else if (!inv_phase) begin
							// down the column, then next column, then M
							if (r != LAST) begin
								r <= r + 1'b1;
							end else if (c != LAST) begin
								c <= c + 1'b1;
								r <= c + 1'b1;
							end else begin
								inv_phase <= 1'b1;
								r <= '0;
								c <= '0;
							end
						end else if (c != r) begin
							c <= c + 1'b1;
						end else if (r != LAST) begin
							r <= r + 1'b1;
							c <= '0;
						end else begin
							fact_done <= 1'b1;
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if (state == S_INIT)
			acc <= inv_phase ? '0 : 64'(a_mat[r*N + c]);
		else if (state == S_MAC && k != k_end)
			acc <= inv_phase ? acc + (prod >>> minv_pkg::FRAC) : acc - (prod >>> minv_pkg::FRAC);
		if (state == S_WAIT && arith_rsp.valid && !arith_rsp.fault) begin
			if (inv_phase)
				m_q[r][c] <= arith_rsp.result;
			else
				l_mat[r][c] <= arith_rsp.result;
		end
	end

	// upper triangle of M reads as zero
	always_comb begin
		for (int rr = 0; rr < N; rr++) begin
			for (int cc = 0; cc < N; cc++)
				m_mat[rr*N + cc] = (cc <= rr) ? m_q[rr][cc] : '0;
		end
	end

endmodule

// ==== hw/minv_gram.sv ====
// ####################################################################
// m_mat must stay stable until gram_done; the inverse is symmetric
// but every element is computed
// ####################################################################
module minv_gram #(
	parameter int N = 3
) (
	input  logic                      i,
	input  logic                      arst_n,
	input  logic                      fact_done,
	input  minv_pkg::word_t [N*N-1:0] m_mat,
	output minv_pkg::word_t [N*N-1:0] inv_mat,
	output logic                      gram_done
);
	localparam int IW = $clog2(N + 1);
	localparam logic [IW-1:0] LAST = IW'(N - 1);

	logic run;
	logic [IW-1:0] r;
	logic [IW-1:0] c;
	logic [IW-1:0] k;
	minv_pkg::word_t mul_a;
	minv_pkg::word_t mul_b;
	logic signed [63:0] prod;
	logic signed [63:0] acc;
	logic signed [63:0] sum;

	// inv_rc = sum over k of m_kr * m_kc
	assign mul_a = m_mat[k*N + r];
	assign mul_b = m_mat[k*N + c];
	assign prod = mul_a * mul_b;
	assign sum = acc + (prod >>> minv_pkg::FRAC);

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
			r <= '0;
			c <= '0;
			k <= '0;
			gram_done <= 1'b0;
			inv_mat <= '0;
		end else begin
			gram_done <= 1'b0;
			if (fact_done) begin
				run <= 1'b1;
				r <= '0;
				c <= '0;
				k <= '0;
			end else if (run) begin
				if (k != LAST) begin
					k <= k + 1'b1;
				end else begin
					k <= '0;
					inv_mat[r*N + c] <= sum[31:0];
					if (c != LAST) begin
						c <= c + 1'b1;
					end else if (r != LAST) begin
						r <= r + 1'b1;
						c <= '0;
					end else begin
						run <= 1'b0;
						gram_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (fact_done || (run && k == LAST))
			acc <= '0;
		else if (run)
			acc <= sum;
	end

endmodule

// ==== hw/minv_pkg.sv ====
// ####################################################################
// signed Q16.16 words; matrix size N is a module parameter (at most 8)
// ####################################################################
package minv_pkg;

	typedef logic signed [31:0] word_t;

	localparam int FRAC = 16;
	localparam word_t ONE = 32'sh0001_0000;

	// byte offsets, element (r,c) at base + 4*(r*N + c)
	localparam logic [31:0] REG_CTRL     = 32'h0000_0000;
	localparam logic [31:0] REG_STATUS   = 32'h0000_0004;
	localparam logic [31:0] REG_A_BASE   = 32'h0000_0100;
	localparam logic [31:0] REG_INV_BASE = 32'h0000_0200;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [31:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic        wvalid;
		logic        bready;
		logic [31:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic [1:0]  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		logic [1:0]  rresp;
		logic        rvalid;
	} axil_rsp_t;

	typedef enum logic {
		OP_DIV,
		OP_SQRT
	} arith_op_e;

	// one request word, seen as a quotient pair or as a radicand
	typedef union packed {
		struct packed {
			word_t num;
			word_t den;
		} div;
		logic [63:0] radicand;
	} arith_arg_u;

	typedef struct packed {
		logic       valid;
		arith_op_e  op;
		arith_arg_u arg;
	} arith_req_t;

	typedef struct packed {
		logic  valid;
		word_t result;
		logic  fault;
	} arith_rsp_t;

endpackage

// ==== hw/minv_regs.sv ====
// ####################################################################
// full-word writes only; element index ignores address bits 1:0
// ####################################################################
module minv_regs #(
	parameter int N = 3
) (
	input  logic                            i,
	input  logic                            arst_n,
	input  minv_pkg::axil_req_t             axil_req,
	output minv_pkg::axil_rsp_t             axil_rsp,
	output minv_pkg::word_t [N*N-1:0]       a_mat,
	output logic                            start,
	input  logic                            fact_fail,
	input  logic                            gram_done,
	input  minv_pkg::word_t [N*N-1:0]       inv_mat,
	output logic                            done
);
	localparam logic [31:0] SPAN = 32'(4 * N * N);

	logic busy;
	logic error;
	logic bvalid;
	logic rvalid;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic [31:0] rdata;
	logic wr_go;
	logic rd_go;
	logic wr_ctrl;
	logic wr_a;
	logic rd_a;
	logic rd_inv;
	logic [31:0] wr_off;
	logic [31:0] rd_off_a;
	logic [31:0] rd_off_inv;

	// one transaction per channel until its response is taken
	assign wr_go = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign rd_go = axil_req.arvalid && !rvalid;

	// offsets below a base wrap high and miss the region
	assign wr_off = axil_req.awaddr - minv_pkg::REG_A_BASE;
	assign wr_a = wr_off < SPAN;
	assign wr_ctrl = axil_req.awaddr == minv_pkg::REG_CTRL;
	assign rd_off_a = axil_req.araddr - minv_pkg::REG_A_BASE;
	assign rd_off_inv = axil_req.araddr - minv_pkg::REG_INV_BASE;
	assign rd_a = rd_off_a < SPAN;
	assign rd_inv = rd_off_inv < SPAN;

	always_ff @(posedge i or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			start <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			a_mat <= '0;
		end else begin
			start <= 1'b0;
			if (wr_go) begin
				bvalid <= 1'b1;
				if (wr_ctrl && axil_req.wdata[0] && !busy) begin
					busy <= 1'b1;
					done <= 1'b0;
					error <= 1'b0;
					start <= 1'b1;
				end
				if (wr_a && !busy)
					a_mat[wr_off[7:2]] <= axil_req.wdata;
			end else if (axil_req.bready) begin
				bvalid <= 1'b0;
			end
			if (rd_go)
				rvalid <= 1'b1;
			else if (axil_req.rready)
				rvalid <= 1'b0;
			// end of run
			if (gram_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (fact_fail) begin
				busy <= 1'b0;
				error <= 1'b1;
			end
		end
	end

	always_ff @(posedge i) begin
		if (wr_go)
			bresp <= (wr_ctrl || (wr_a && !busy)) ? minv_pkg::RESP_OKAY : minv_pkg::RESP_SLVERR;
		if (rd_go) begin
			rresp <= minv_pkg::RESP_OKAY;
			if (axil_req.araddr == minv_pkg::REG_CTRL)
				rdata <= '0;
			else if (axil_req.araddr == minv_pkg::REG_STATUS)
				rdata <= {29'b0, error, done, busy};
			else if (rd_a)
				rdata <= a_mat[rd_off_a[7:2]];
			else if (rd_inv)
				rdata <= inv_mat[rd_off_inv[7:2]];
			else begin
				rdata <= '0;
				rresp <= minv_pkg::RESP_SLVERR;
			end
		end
	end

	always_comb begin
		axil_rsp.awready = wr_go;
		axil_rsp.wready = wr_go;
		axil_rsp.bresp = bresp;
		axil_rsp.bvalid = bvalid;
		axil_rsp.arready = rd_go;
		axil_rsp.rdata = rdata;
		axil_rsp.rresp = rresp;
		axil_rsp.rvalid = rvalid;
	end

endmodule

// ==== hw/minv_top.sv ====
// ####################################################################
// one matrix in flight; N up to 8, A must be symmetric positive definite
// ####################################################################
module minv_top #(
	parameter int N = 3
) (
	input  logic                i,
	input  logic                arst_n,
	input  minv_pkg::axil_req_t axil_req,
	output minv_pkg::axil_rsp_t axil_rsp,
	output logic                done
);
	minv_pkg::word_t [N*N-1:0] a_mat;
	minv_pkg::word_t [N*N-1:0] m_mat;
	minv_pkg::word_t [N*N-1:0] inv_mat;
	minv_pkg::arith_req_t arith_req;
	minv_pkg::arith_rsp_t arith_rsp;
	logic start;
	logic fact_done;
	logic fact_fail;
	logic gram_done;

	minv_regs #(.N(N)) i_regs (
		.i(i),
		.arst_n(arst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.a_mat(a_mat),
		.start(start),
		.fact_fail(fact_fail),
		.gram_done(gram_done),
		.inv_mat(inv_mat),
		.done(done)
	);

	minv_factor #(.N(N)) i_factor (
		.i(i),
		.arst_n(arst_n),
		.start(start),
		.a_mat(a_mat),
		.arith_req(arith_req),
		.arith_rsp(arith_rsp),
		.m_mat(m_mat),
		.fact_done(fact_done),
		.fact_fail(fact_fail)
	);

	// shared by the cholesky and triangular inverse steps
	minv_divsqrt i_divsqrt (
		.i(i),
		.arst_n(arst_n),
		.req(arith_req),
		.rsp(arith_rsp)
	);

	minv_gram #(.N(N)) i_gram (
		.i(i),
		.arst_n(arst_n),
		.fact_done(fact_done),
		.m_mat(m_mat),
		.inv_mat(inv_mat),
		.gram_done(gram_done)
	);

endmodule

// ==== tests/minv_tb_util.svh ====
// ######################################################################
// included inside minv_tb; uses its clock, bus signals, N and counters
// ######################################################################
`ifndef MINV_TB_UTIL_SVH
`define MINV_TB_UTIL_SVH

// a second write offered while the response waits must be refused
task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
	int stall;
	stall = (max_stall > 0) ? int'($urandom_range(max_stall)) : 0;
	@(posedge i);
	axil_req.awaddr <= addr;
	axil_req.wdata <= data;
	axil_req.awvalid <= 1'b1;
	axil_req.wvalid <= 1'b1;
	axil_req.bready <= (stall == 0);
	@(negedge i);
	while (!axil_rsp.awready)
		@(negedge i);
	if (!axil_rsp.wready) begin
		$display("at %0t ns: wready did not pulse together with awready", $time);
		errors++;
	end
	@(posedge i);
	if (stall > 0) begin
		axil_req.awaddr <= minv_pkg::REG_STATUS;
	end else begin
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
	end
	@(negedge i);
	resp = axil_rsp.bresp;
	for (int n = 0; n < stall; n++) begin
		if (!axil_rsp.bvalid || axil_rsp.bresp !== resp) begin
			$display("at %0t ns: write response changed before it was accepted", $time);
			errors++;
		end
		if (axil_rsp.awready || axil_rsp.wready) begin
			$display("at %0t ns: second write accepted while a response was pending", $time);
			errors++;
		end
		@(posedge i);
		if (n == stall - 1) begin
			axil_req.awvalid <= 1'b0;
			axil_req.wvalid <= 1'b0;
			axil_req.bready <= 1'b1;
		end
		@(negedge i);
	end
	if (!axil_rsp.bvalid) begin
		$display("at %0t ns: write got no response", $time);
		errors++;
	end
	@(posedge i);
endtask

// same scheme on the read channel with a second read as the probe
task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
	int stall;
	stall = (max_stall > 0) ? int'($urandom_range(max_stall)) : 0;
	@(posedge i);
	axil_req.araddr <= addr;
	axil_req.arvalid <= 1'b1;
	axil_req.rready <= (stall == 0);
	@(negedge i);
	while (!axil_rsp.arready)
		@(negedge i);
	@(posedge i);
	if (stall > 0)
		axil_req.araddr <= minv_pkg::REG_CTRL;
	else
		axil_req.arvalid <= 1'b0;
	@(negedge i);
	data = axil_rsp.rdata;
	resp = axil_rsp.rresp;
	for (int n = 0; n < stall; n++) begin
		if (!axil_rsp.rvalid || axil_rsp.rdata !== data || axil_rsp.rresp !== resp) begin
			$display("at %0t ns: read response changed before it was accepted", $time);
			errors++;
		end
		if (axil_rsp.arready) begin
			$display("at %0t ns: second read accepted while a response was pending", $time);
			errors++;
		end
		@(posedge i);
		if (n == stall - 1) begin
			axil_req.arvalid <= 1'b0;
			axil_req.rready <= 1'b1;
		end
		@(negedge i);
	end
	if (!axil_rsp.rvalid) begin
		$display("at %0t ns: read got no response", $time);
		errors++;
	end
	@(posedge i);
endtask

// Q16.16 product shifted back and kept wide for the sums
function automatic longint scaled_product(input minv_pkg::word_t x, input minv_pkg::word_t y);
	longint p;
	p = longint'(x) * longint'(y);
	return p >>> minv_pkg::FRAC;
endfunction

// truncates toward zero and keeps the low word
function automatic minv_pkg::word_t quotient(input minv_pkg::word_t num,
		input minv_pkg::word_t den);
	longint q;
	q = (longint'(num) <<< minv_pkg::FRAC) / longint'(den);
	return q[31:0];
endfunction

function automatic minv_pkg::word_t root_floor(input longint v);
	longint r;
	longint t;
	r = 0;
	for (int b = 30; b >= 0; b--) begin
		t = r + (longint'(1) <<< b);
		if (t * t <= v)
			r = t;
	end
	return r[31:0];
endfunction

// fills inv_exp from a_val; inv_exp is left alone when A is refused
function automatic bit reference_inverse();
	minv_pkg::word_t l [N][N];
	minv_pkg::word_t m [N][N];
	minv_pkg::word_t s;
	longint acc;
	m = '{default: '0};
	for (int j = 0; j < N; j++) begin
		for (int r = j; r < N; r++) begin
			acc = longint'(a_val[r*N + j]);
			for (int k = 0; k < j; k++)
				acc -= scaled_product(l[r][k], l[j][k]);
			s = acc[31:0];
			if (r == j) begin
				if (s <= 0)
					return 1'b0;
				l[j][j] = root_floor(longint'(s) <<< minv_pkg::FRAC);
			end else begin
				l[r][j] = quotient(s, l[j][j]);
			end
		end
	end
	// inverse of the lower factor, row by row
	for (int r = 0; r < N; r++) begin
		for (int c = 0; c <= r; c++) begin
			acc = 0;
			for (int k = c; k < r; k++)
				acc += scaled_product(l[r][k], m[k][c]);
			s = acc[31:0];
			m[r][c] = quotient((r == c) ? minv_pkg::ONE : -s, l[r][r]);
		end
	end
	for (int r = 0; r < N; r++) begin
		for (int c = 0; c < N; c++) begin
			acc = 0;
			for (int k = 0; k < N; k++)
				acc += scaled_product(m[k][r], m[k][c]);
			inv_exp[r*N + c] = acc[31:0];
		end
	end
	return 1'b1;
endfunction

`endif

// ==== tests/minv_tb.sv ====
// ######################################################################
// N = 3; random SPD matrices from a fixed seed, compared bit for bit
// ######################################################################
module minv_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N = 3;
	localparam int CLK_NS = 20;
	localparam int RUN_CYCLES = N * N * 40 + N * N * N + 200;
	// run budget doubled as margin for register traffic
	localparam longint TIMEOUT_NS = 2 * 40 * RUN_CYCLES * CLK_NS;

	logic i = 1'b0;
	logic arst_n;
	minv_pkg::axil_req_t axil_req;
	minv_pkg::axil_rsp_t axil_rsp;
	logic done;

	minv_pkg::word_t a_val [N*N];
	minv_pkg::word_t inv_exp [N*N];
	int errors;
	int max_stall;
	int test_count;
	int errors_at_start;
	string test_name;

	`include "minv_tb_util.svh"

	minv_top #(.N(N)) i_dut (
		.i(i),
		.arst_n(arst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.done(done)
	);

	always #(CLK_NS / 2) i = ~i;

	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns, the run did not complete", TIMEOUT_NS);
		$display("Done: errors found");
		$finish;
	end

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
		errors++;
	endtask

	task automatic new_test(input string name);
		test_count++;
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic summarize_test();
		if (errors == errors_at_start)
			$display("test %0d %s: ok", test_count, test_name);
		else
			$display("test %0d %s: %0d errors", test_count, test_name, errors - errors_at_start);
	endtask

	// A = B'B + 4I with B on a 0.25 grid within +-2.0
	task automatic random_spd();
		int q [N][N];
		int sum;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++)
				q[r][c] = int'($urandom_range(16)) - 8;
		end
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				sum = 0;
				for (int k = 0; k < N; k++)
					sum += q[k][r] * q[k][c];
				a_val[r*N + c] = sum * 4096 + ((r == c) ? 4 * minv_pkg::ONE : 0);
			end
		end
	endtask

	task automatic load_matrix();
		logic [1:0] resp;
		for (int e = 0; e < N * N; e++) begin
			write_word(minv_pkg::REG_A_BASE + 32'(4 * e), a_val[e], resp);
			if (resp !== minv_pkg::RESP_OKAY)
				report_mismatch($sformatf("bresp A(%0d,%0d)", e / N, e % N),
					32'(resp), 32'(minv_pkg::RESP_OKAY));
		end
	endtask

	task automatic start_run();
		logic [1:0] resp;
		write_word(minv_pkg::REG_CTRL, 32'h1, resp);
		if (resp !== minv_pkg::RESP_OKAY)
			report_mismatch("bresp start", 32'(resp), 32'(minv_pkg::RESP_OKAY));
	endtask

	task automatic wait_idle(output logic [31:0] status);
		logic [1:0] resp;
		status = 32'h1;
		while (status[0] === 1'b1)
			read_word(minv_pkg::REG_STATUS, status, resp);
	endtask

	task automatic check_inverse();
		logic [31:0] got;
		logic [1:0] resp;
		for (int e = 0; e < N * N; e++) begin
			read_word(minv_pkg::REG_INV_BASE + 32'(4 * e), got, resp);
			if (got !== inv_exp[e])
				report_mismatch($sformatf("inverse(%0d,%0d)", e / N, e % N), got, inv_exp[e]);
		end
	endtask

	// ok selects done or error as the expected ending
	task automatic finish_run(input bit ok);
		logic [31:0] status;
		wait_idle(status);
		if (status !== {29'b0, !ok, ok, 1'b0})
			report_mismatch("status at end of run", status, {29'b0, !ok, ok, 1'b0});
		if (done !== ok)
			report_mismatch("done output", 32'(done), 32'(ok));
		check_inverse();
	endtask

	initial begin
		logic [31:0] data;
		logic [31:0] pattern;
		logic [1:0] resp;
		bit ok;
		arst_n <= 1'b0;
		axil_req <= '0;
		errors = 0;
		max_stall = 0;
		test_count = 0;
		inv_exp = '{default: '0};
		void'($urandom(12932));
		repeat (8) @(posedge i);
		arst_n <= 1'b1;

		new_test("register access and reset");
		if (done !== 1'b0)
			report_mismatch("done output after reset", 32'(done), 32'h0);
		read_word(minv_pkg::REG_STATUS, data, resp);
		if (data !== 32'h0)
			report_mismatch("status after reset", data, 32'h0);
		check_inverse();
		pattern = $urandom();
		write_word(minv_pkg::REG_A_BASE + 32'(4 * 5), pattern, resp);
		if (resp !== minv_pkg::RESP_OKAY)
			report_mismatch("bresp A(1,2)", 32'(resp), 32'(minv_pkg::RESP_OKAY));
		read_word(minv_pkg::REG_A_BASE + 32'(4 * 5), data, resp);
		if (data !== pattern)
			report_mismatch("A(1,2) read back", data, pattern);
		read_word(32'h0000_0300, data, resp);
		if (resp !== minv_pkg::RESP_SLVERR)
			report_mismatch("rresp unmapped", 32'(resp), 32'(minv_pkg::RESP_SLVERR));
		write_word(minv_pkg::REG_STATUS, 32'h1, resp);
		if (resp !== minv_pkg::RESP_SLVERR)
			report_mismatch("bresp status write", 32'(resp), 32'(minv_pkg::RESP_SLVERR));
		summarize_test();

		new_test("random inversions");
		for (int t = 0; t < 30; t++) begin
			random_spd();
			ok = reference_inverse();
			load_matrix();
			start_run();
			finish_run(ok);
		end
		summarize_test();

		new_test("back-pressure");
		max_stall = 6;
		random_spd();
		ok = reference_inverse();
		load_matrix();
		start_run();
		finish_run(ok);
		for (int e = 0; e < N * N; e++) begin
			read_word(minv_pkg::REG_A_BASE + 32'(4 * e), data, resp);
			if (data !== a_val[e])
				report_mismatch($sformatf("A(%0d,%0d) read back", e / N, e % N), data, a_val[e]);
		end
		max_stall = 0;
		summarize_test();

		new_test("busy protection");
		random_spd();
		ok = reference_inverse();
		load_matrix();
		start_run();
		write_word(minv_pkg::REG_A_BASE, a_val[0] + minv_pkg::ONE, resp);
		if (resp !== minv_pkg::RESP_SLVERR)
			report_mismatch("bresp A write while busy", 32'(resp), 32'(minv_pkg::RESP_SLVERR));
		// second start lands in the middle of the run
		write_word(minv_pkg::REG_CTRL, 32'h1, resp);
		if (resp !== minv_pkg::RESP_OKAY)
			report_mismatch("bresp start while busy", 32'(resp), 32'(minv_pkg::RESP_OKAY));
		read_word(minv_pkg::REG_STATUS, data, resp);
		if (data[0] !== 1'b1)
			report_mismatch("busy during run", 32'(data[0]), 32'h1);
		finish_run(ok);
		read_word(minv_pkg::REG_A_BASE, data, resp);
		if (data !== a_val[0])
			report_mismatch("A(0,0) after busy write", data, a_val[0]);
		read_word(minv_pkg::REG_STATUS, data, resp);
		if (data !== 32'h2)
			report_mismatch("status after refused start", data, 32'h2);
		summarize_test();

		new_test("non positive definite");
		random_spd();
		a_val[0] = -a_val[0];
		ok = reference_inverse();
		if (ok) begin
			$display("reference model accepted a matrix with a negative diagonal");
			errors++;
		end
		load_matrix();
		start_run();
		finish_run(1'b0);
		summarize_test();

		new_test("recovery");
		random_spd();
		ok = reference_inverse();
		load_matrix();
		start_run();
		finish_run(ok);
		summarize_test();

		$display("tests %0d, errors %0d", test_count, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
